// File: ex_stage.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_divider.sv
hw/ex_resolve.sv
hw/ex_stage.sv
sim/tb_ex_stage.sv

// File: hw/ex_alu.sv
/*
  combinational integer alu
  shifts use the low SHAMT_W bits of operand_b
  compares return their flag in bit 0, upper bits zero
*/
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
    input  logic [`XLEN-1:0] operand_a,
    input  logic [`XLEN-1:0] operand_b,
    input  alu_op_e          alu_op,
    output logic [`XLEN-1:0] alu_out
);

    logic [`SHAMT_W-1:0] shamt;
    logic                lt_s;
    logic                lt_u;
    logic                eq;

    assign shamt = operand_b[`SHAMT_W-1:0];
    assign lt_s  = $signed(operand_a) < $signed(operand_b);
    assign lt_u  = operand_a < operand_b;
    assign eq    = operand_a == operand_b;

    always_comb begin
        alu_out = '0;
        case (alu_op)
            ALU_ADD:  alu_out = operand_a + operand_b;
            ALU_SUB:  alu_out = operand_a - operand_b;
            ALU_SLL:  alu_out = operand_a << shamt;
            ALU_SRL:  alu_out = operand_a >> shamt;
            ALU_SRA:  alu_out = $signed(operand_a) >>> shamt;    // keep sign bits
            ALU_AND:  alu_out = operand_a & operand_b;
            ALU_OR:   alu_out = operand_a | operand_b;
            ALU_XOR:  alu_out = operand_a ^ operand_b;

            // set-less-than and the branch compares
            ALU_SLT,
            ALU_LT:   alu_out[0] = lt_s;
            ALU_SLTU,
            ALU_LTU:  alu_out[0] = lt_u;
            ALU_EQ:   alu_out[0] = eq;
            ALU_NE:   alu_out[0] = !eq;
            ALU_GE:   alu_out[0] = !lt_s;
            ALU_GEU:  alu_out[0] = !lt_u;
            default:  alu_out = '0;
        endcase
    end

endmodule

// File: hw/ex_decode.sv
/*
  operand select and dispatch for one accepted instruction
  accept must only rise when the stage is ready; no queueing here
  jumps always compute their target with an add
*/
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_decode import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  id_ex_t           in_bits,
    input  logic             accept,
    input  logic             div_busy,
    output logic [`XLEN-1:0] operand_a,
    output logic [`XLEN-1:0] operand_b,
    output alu_op_e          alu_op,
    output logic             div_start,
    output div_op_e          div_op,
    output logic [`XLEN-1:0] dividend,
    output logic [`XLEN-1:0] divisor,
    output logic             issue_valid,
    output id_ex_t           issue_bits
);

    logic is_div;
    logic is_jump;

    assign is_div  = (in_bits.kind == KIND_DIV);
    assign is_jump = (in_bits.kind == KIND_JAL) || (in_bits.kind == KIND_JALR);

    // ----------------------------------------
    // operands
    // ----------------------------------------
    always_comb begin
        case (in_bits.src1_sel)
            SRC1_PC:  operand_a = in_bits.pc;       // auipc, jal
            SRC1_RS1: operand_a = in_bits.rs1_data;
            default:  operand_a = '0;               // lui
        endcase
    end

    assign operand_b = (in_bits.src2_sel == SRC2_RS2) ? in_bits.rs2_data : in_bits.imm;

    // target of jal / jalr comes out of the adder
    assign alu_op = is_jump ? ALU_ADD : in_bits.alu_op;

    // ----------------------------------------
    // dispatch
    // ----------------------------------------
    assign div_start   = accept && is_div;
    assign div_op      = in_bits.div_op;
    assign dividend    = in_bits.rs1_data;
    assign divisor     = in_bits.rs2_data;

    assign issue_valid = accept && !is_div;   // divides report through the divider
    assign issue_bits  = in_bits;

    // the top-level ready must keep a second divide away from a running one
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        div_busy |-> !div_start);

    // nothing is taken without a request from decode
    a_accept_valid: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> in_valid);

endmodule

// File: hw/ex_divider.sv
/*
  restoring divider, one quotient bit per clock over DIV_STEPS cycles
  start must not be raised while busy; result is valid only while done
  division by zero and overflow follow the RISC-V M rules
*/
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_divider import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  div_op_e          div_op,
    input  logic [`XLEN-1:0] dividend,
    input  logic [`XLEN-1:0] divisor,
    output logic             busy,
    output logic             done,
    output logic [`XLEN-1:0] result
);

    logic                  signed_op;
    logic                  a_neg;
    logic                  b_neg;
    logic [`XLEN-1:0]      a_mag;
    logic [`XLEN-1:0]      b_mag;

    logic [`DIV_CNT_W-1:0] count;
    logic [`XLEN-1:0]      quot_q;      // dividend bits shift out, quotient bits in
    logic [`XLEN-1:0]      rem_q;
    logic [`XLEN-1:0]      div_mag_q;
    logic [`XLEN-1:0]      dividend_q;
    logic                  want_rem_q;
    logic                  q_neg_q;
    logic                  r_neg_q;
    logic                  zero_q;

    logic [`XLEN:0]        rem_shift;
    logic [`XLEN:0]        rem_diff;
    logic [`XLEN-1:0]      quot_fix;
    logic [`XLEN-1:0]      rem_fix;

    // ----------------------------------------
    // operand magnitudes
    // ----------------------------------------
    assign signed_op = (div_op == DIV_DIV) || (div_op == DIV_REM);
    assign a_neg     = signed_op && dividend[`XLEN-1];
    assign b_neg     = signed_op && divisor[`XLEN-1];
    assign a_mag     = a_neg ? -dividend : dividend;   // 0x8000_0000 stays as is
    assign b_mag     = b_neg ? -divisor : divisor;

    // one restoring step
    assign rem_shift = {rem_q, quot_q[`XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, div_mag_q};

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == `DIV_CNT_W'(`DIV_STEPS - 1)) begin
                    busy <= 1'b0;   // last step, result readable next cycle
                    done <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            quot_q     <= a_mag;
            rem_q      <= '0;
            div_mag_q  <= b_mag;
            dividend_q <= dividend;
            want_rem_q <= (div_op == DIV_REM) || (div_op == DIV_REMU);
            q_neg_q    <= a_neg ^ b_neg;
            r_neg_q    <= a_neg;                 // remainder follows dividend sign
            zero_q     <= (divisor == '0);
        end else if (busy) begin
            quot_q <= {quot_q[`XLEN-2:0], !rem_diff[`XLEN]};
            rem_q  <= rem_diff[`XLEN] ? rem_shift[`XLEN-1:0] : rem_diff[`XLEN-1:0];
        end
    end

    // most negative / -1 lands on 0x8000_0000 with rem 0, no special case needed
    assign quot_fix = q_neg_q ? -quot_q : quot_q;
    assign rem_fix  = r_neg_q ? -rem_q : rem_q;

    always_comb begin
        if (zero_q) begin
            result = want_rem_q ? dividend_q : '1;
        end else begin
            result = want_rem_q ? rem_fix : quot_fix;
        end
    end

    // done closes exactly DIV_STEPS busy cycles after start
    a_done_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $fell(busy) && $past(start, `DIV_STEPS + 1));

endmodule

// File: hw/ex_macros.svh
/*
  execute stage widths and counts, shared by the package and the RTL
  DIV_STEPS must equal XLEN; the divider retires one quotient bit per step
  DIV_CNT_W must be wide enough to count DIV_STEPS
*/
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// ----------------------------------------
// datapath
// ----------------------------------------
`define XLEN        32
`define REG_AW      5
`define SHAMT_W     5       // shift amount taken from low operand bits

// ----------------------------------------
// control flow
// ----------------------------------------
`define PC_STEP     4       // no compressed instructions

// ----------------------------------------
// divider
// ----------------------------------------
`define DIV_STEPS   `XLEN
`define DIV_CNT_W   6

`endif

// File: hw/ex_pkg.sv
/*
  types of the execute stage
  decode delivers fully classified instructions; no raw opcode travels here
*/
`include "ex_macros.svh"

package ex_pkg;

    // unit class of an instruction
    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_DIV
    } op_kind_e;

    // compares give 0 or 1
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_AND, ALU_OR,  ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
        ALU_LT,  ALU_GE,  ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } div_op_e;

    typedef enum logic [1:0] {
        SRC1_ZERO,
        SRC1_PC,
        SRC1_RS1
    } src1_sel_e;

    typedef enum logic {
        SRC2_IMM,
        SRC2_RS2
    } src2_sel_e;

    // decode -> execute
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`REG_AW-1:0] rd_addr;
        logic               rd_we;
        op_kind_e           kind;
        alu_op_e            alu_op;
        div_op_e            div_op;
        src1_sel_e          src1_sel;
        src2_sel_e          src2_sel;
        logic               pred_taken;     // fetch guessed taken
        logic [`XLEN-1:0]   pred_pc;        // fetch guessed target
    } id_ex_t;

    // execute -> memory
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rd_addr;
        logic               rd_we;
        logic [`XLEN-1:0]   rd_wdata;
    } ex_mem_t;

    // execute -> fetch
    typedef struct packed {
        logic               is_branch;
        logic               taken;
        logic [`XLEN-1:0]   target;
        logic               miss;
        logic [`XLEN-1:0]   redirect_pc;
    } branch_res_t;

endpackage

// File: hw/ex_resolve.sv
/*
  result select, branch check and the output register to the memory stage
  one instruction in flight; the top level must hold off issue while full
  a divide's result always finds the output register empty
*/
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_resolve import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue_valid,
    input  id_ex_t           issue_bits,
    input  logic             div_start,
    input  logic [`XLEN-1:0] alu_out,
    input  logic             div_done,
    input  logic [`XLEN-1:0] div_result,
    input  logic             out_ready,
    output logic             out_valid,
    output ex_mem_t          out_bits,
    output branch_res_t      out_branch,
    output logic             out_full
);

    logic               is_jump;
    logic               is_cond;
    logic [`XLEN-1:0]   pc_step;
    logic [`XLEN-1:0]   pc_imm;
    logic               load;
    ex_mem_t            next_bits;
    branch_res_t        next_branch;

    // destination of the divide in flight
    logic [`XLEN-1:0]   div_pc;
    logic [`REG_AW-1:0] div_rd_addr;
    logic               div_rd_we;

    assign is_jump = (issue_bits.kind == KIND_JAL) || (issue_bits.kind == KIND_JALR);
    assign is_cond = (issue_bits.kind == KIND_BRANCH);
    assign pc_step = issue_bits.pc + `XLEN'(`PC_STEP);
    assign pc_imm  = issue_bits.pc + issue_bits.imm;

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_pc      <= issue_bits.pc;
            div_rd_addr <= issue_bits.rd_addr;
            div_rd_we   <= issue_bits.rd_we;
        end
    end

    // ----------------------------------------
    // result and branch check
    // ----------------------------------------
    always_comb begin
        next_bits   = '0;
        next_branch = '0;
        if (div_done) begin
            next_bits.pc       = div_pc;
            next_bits.rd_addr  = div_rd_addr;
            next_bits.rd_we    = div_rd_we;
            next_bits.rd_wdata = div_result;
        end else begin
            next_bits.pc       = issue_bits.pc;
            next_bits.rd_addr  = issue_bits.rd_addr;
            next_bits.rd_we    = issue_bits.rd_we;
            next_bits.rd_wdata = is_jump ? pc_step : alu_out;   // link address

            if (is_jump || is_cond) begin
                next_branch.is_branch = 1'b1;
                next_branch.taken     = is_jump || alu_out[0];
                next_branch.target    = is_jump ? alu_out : pc_imm;
                if (next_branch.taken) begin
                    // wrong direction or wrong target
                    next_branch.miss = !issue_bits.pred_taken ||
                                       (issue_bits.pred_pc != next_branch.target);
                    next_branch.redirect_pc = next_branch.target;
                end else begin
                    next_branch.miss        = issue_bits.pred_taken;
                    next_branch.redirect_pc = pc_step;
                end
            end
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    assign load = issue_valid || div_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_bits   <= next_bits;
            out_branch <= next_branch;
        end
    end

    assign out_full = out_valid;

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_bits) &&
                                       $stable(out_branch)));

endmodule

// File: hw/ex_stage.sv
/*
  execute stage top: decode, alu, divider and result register
  valid/ready on both sides, one instruction in flight
  in_ready drops during a divide and while the result waits on out_ready
*/
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage import ex_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  id_ex_t      in_bits,
    output logic        in_ready,
    output logic        out_valid,
    output ex_mem_t     out_bits,
    output branch_res_t out_branch,
    input  logic        out_ready
);

    logic             accept;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] alu_out;
    logic             div_start;
    div_op_e          div_op;
    logic [`XLEN-1:0] dividend;
    logic [`XLEN-1:0] divisor;
    logic             div_busy;
    logic             div_done;
    logic [`XLEN-1:0] div_result;
    logic             issue_valid;
    id_ex_t           issue_bits;
    logic             out_full;

    // free slot, or the held result leaves this cycle
    // a divide keeps issue off until its result is registered
    assign in_ready = !div_busy && !div_done && !(out_full && !out_ready);
    assign accept   = in_valid && in_ready;

    ex_decode i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_bits     (in_bits),
        .accept      (accept),
        .div_busy    (div_busy),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .alu_op      (alu_op),
        .div_start   (div_start),
        .div_op      (div_op),
        .dividend    (dividend),
        .divisor     (divisor),
        .issue_valid (issue_valid),
        .issue_bits  (issue_bits)
    );

    ex_alu i_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_op    (alu_op),
        .alu_out   (alu_out)
    );

    ex_divider i_divider (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .div_op   (div_op),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (div_busy),
        .done     (div_done),
        .result   (div_result)
    );

    ex_resolve i_resolve (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_bits  (issue_bits),
        .div_start   (div_start),
        .alu_out     (alu_out),
        .div_done    (div_done),
        .div_result  (div_result),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_bits    (out_bits),
        .out_branch  (out_branch),
        .out_full    (out_full)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
# the run counts as passed only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

top=tb_ex_stage
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -f ex_stage.f -o "$top" \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/"$top" > "$log" 2>&1
cat "$log"

grep -qx "all tests passed" "$log" \
    && { echo "simulation PASSED"; exit 0; } \
    || { echo "simulation FAILED"; exit 1; }

// File: sim/tb_ex_stage.sv
/*
  table-driven testbench for the execute stage
  one instruction in flight; each result is taken before the next row is driven
  expected values come from a behavioral model of the stage rules
  needs a simulator run with assertions enabled
*/
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam logic [`XLEN-1:0] min_neg = {1'b1, {(`XLEN-1){1'b0}}};

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    id_ex_t      in_bits;
    logic        in_ready;
    logic        out_valid;
    ex_mem_t     out_bits;
    branch_res_t out_branch;
    logic        out_ready;

    // stimulus table with its expected results
    id_ex_t      rows[$];
    int          stalls[$];         // cycles out_ready stays low per row
    ex_mem_t     exp_bits[$];
    branch_res_t exp_branch[$];
    int          n_rows = 0;
    int          n_results = 0;
    int          seed = 32'h42d2;

    ex_stage i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_bits    (in_bits),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_bits   (out_bits),
        .out_branch (out_branch),
        .out_ready  (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // transfers to the memory stage, counted on their own
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready)
            n_results++;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [`XLEN-1:0] alu_model(input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b,
                                                   input alu_op_e op);
        logic [4:0] sh;
        logic       lts;
        logic       ltu;
        sh  = b[4:0];
        lts = (a ^ min_neg) < (b ^ min_neg);   // sign flip turns signed order unsigned
        ltu = a < b;
        case (op)
            ALU_ADD:           return a + b;
            ALU_SUB:           return a - b;
            ALU_SLL:           return a << sh;
            ALU_SRL:           return a >> sh;
            ALU_SRA:           return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
            ALU_AND:           return a & b;
            ALU_OR:            return a | b;
            ALU_XOR:           return a ^ b;
            ALU_SLT, ALU_LT:   return `XLEN'(lts);
            ALU_SLTU, ALU_LTU: return `XLEN'(ltu);
            ALU_EQ:            return `XLEN'(a == b);
            ALU_NE:            return `XLEN'(a != b);
            ALU_GE:            return `XLEN'(!lts);
            default:           return `XLEN'(!ltu);   // geu
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] div_model(input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b,
                                                   input div_op_e op);
        logic rem;
        logic sgn;
        int   sa;
        int   sb;
        rem = (op == DIV_REM) || (op == DIV_REMU);
        sgn = (op == DIV_DIV) || (op == DIV_REM);
        sa  = a;
        sb  = b;
        if (b == '0)
            return rem ? a : '1;
        if (sgn && a == min_neg && b == '1)     // overflow case
            return rem ? '0 : a;
        if (sgn)
            return rem ? `XLEN'(sa % sb) : `XLEN'(sa / sb);
        return rem ? a % b : a / b;
    endfunction

    task automatic model_row(input id_ex_t ins, output ex_mem_t em, output branch_res_t br);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] link;
        logic             jump;
        a = (ins.src1_sel == SRC1_PC) ? ins.pc :
            (ins.src1_sel == SRC1_RS1) ? ins.rs1_data : '0;
        b = (ins.src2_sel == SRC2_RS2) ? ins.rs2_data : ins.imm;
        jump = ins.kind inside {KIND_JAL, KIND_JALR};
        res  = alu_model(a, b, jump ? ALU_ADD : ins.alu_op);
        link = ins.pc + `PC_STEP;
        em.pc       = ins.pc;
        em.rd_addr  = ins.rd_addr;
        em.rd_we    = ins.rd_we;
        em.rd_wdata = jump ? link : res;
        if (ins.kind == KIND_DIV)
            em.rd_wdata = div_model(ins.rs1_data, ins.rs2_data, ins.div_op);
        br = '0;
        if (jump || ins.kind == KIND_BRANCH) begin
            br.is_branch   = 1'b1;
            br.taken       = jump || res[0];
            br.target      = jump ? res : ins.pc + ins.imm;
            br.redirect_pc = br.taken ? br.target : link;
            br.miss        = br.taken ? (!ins.pred_taken || ins.pred_pc != br.target)
                                      : ins.pred_taken;
        end
    endtask

    // ----------------------------------------
    // table and checks
    // ----------------------------------------
    // mode: 0 prediction right, 1 wrong direction, 2 wrong target
    task automatic push_row(input op_kind_e kind, input alu_op_e op, input div_op_e dop,
                            input src1_sel_e s1, input src2_sel_e s2,
                            input logic [`XLEN-1:0] rs1, input logic [`XLEN-1:0] rs2,
                            input logic [`XLEN-1:0] imm, input int mode);
        id_ex_t      r;
        ex_mem_t     em;
        branch_res_t br;
        r          = '0;
        r.pc       = $random(seed);
        r.pc[1:0]  = 2'b00;
        r.imm      = imm;
        r.rs1_data = rs1;
        r.rs2_data = rs2;
        r.rd_addr  = `REG_AW'($random(seed));
        r.rd_we    = (r.rd_addr != '0);
        r.kind     = kind;
        r.alu_op   = op;
        r.div_op   = dop;
        r.src1_sel = s1;
        r.src2_sel = s2;
        model_row(r, em, br);
        if (br.is_branch) begin
            r.pred_taken = (mode == 1) ? !br.taken : (mode == 2) ? 1'b1 : br.taken;
            r.pred_pc    = (mode == 2) ? br.target + 8 : br.target;
            model_row(r, em, br);
        end
        rows.push_back(r);
        stalls.push_back(int'($unsigned($random(seed)) % 5));
        exp_bits.push_back(em);
        exp_branch.push_back(br);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        assert (got === exp) else
            abort_run($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_hold(input ex_mem_t hb, input branch_res_t hr);
        check_value("out_valid", `XLEN'(out_valid), `XLEN'(1));
        check_value("in_ready", `XLEN'(in_ready), '0);
        assert (out_bits === hb) else
            abort_run($sformatf("ERROR out_bits: got 0x%h expected 0x%h", out_bits, hb));
        assert (out_branch === hr) else
            abort_run($sformatf("ERROR out_branch: got 0x%h expected 0x%h", out_branch, hr));
    endtask

    task automatic run_row(input int idx);
        int          lat;
        ex_mem_t     hb;
        branch_res_t hr;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_bits   <= rows[idx];
        out_ready <= (stalls[idx] == 0);
        do @(negedge clk); while (!in_ready);
        lat = 0;
        do begin
            @(posedge clk);
            if (lat == 0)
                in_valid <= 1'b0;   // taken on this edge
            lat++;
            @(negedge clk);
            if (rows[idx].kind == KIND_DIV && !out_valid)
                check_value("in_ready", `XLEN'(in_ready), '0);
        end while (!out_valid);
        if (rows[idx].kind != KIND_DIV)
            check_value("out_valid latency", `XLEN'(lat), `XLEN'(1));

        check_value("out_bits.pc", out_bits.pc, exp_bits[idx].pc);
        check_value("out_bits.rd_addr", `XLEN'(out_bits.rd_addr), `XLEN'(exp_bits[idx].rd_addr));
        check_value("out_bits.rd_we", `XLEN'(out_bits.rd_we), `XLEN'(exp_bits[idx].rd_we));
        check_value("out_bits.rd_wdata", out_bits.rd_wdata, exp_bits[idx].rd_wdata);
        check_value("out_branch.is_branch", `XLEN'(out_branch.is_branch),
                    `XLEN'(exp_branch[idx].is_branch));
        check_value("out_branch.taken", `XLEN'(out_branch.taken), `XLEN'(exp_branch[idx].taken));
        check_value("out_branch.target", out_branch.target, exp_branch[idx].target);
        check_value("out_branch.miss", `XLEN'(out_branch.miss), `XLEN'(exp_branch[idx].miss));
        check_value("out_branch.redirect_pc", out_branch.redirect_pc,
                    exp_branch[idx].redirect_pc);
        hb = out_bits;
        hr = out_branch;

        // memory stage stalls
        if (stalls[idx] > 0) begin
            repeat (stalls[idx]) begin
                @(posedge clk);
                @(negedge clk);
                check_hold(hb, hr);
            end
            @(posedge clk);
            out_ready <= 1'b1;
            @(negedge clk);
            check_value("out_valid", `XLEN'(out_valid), `XLEN'(1));
        end
        @(posedge clk);             // result leaves here
        @(negedge clk);
        check_value("out_valid after transfer", `XLEN'(out_valid), '0);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] corners[6];
        in_valid  <= 1'b0;
        in_bits   <= '0;
        out_ready <= 1'b1;
        rst_n     <= 1'b0;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1f};

        // alu, all six operand select pairs
        for (int i = 0; i < 18; i++) begin
            a = (i < 12) ? corners[i % 6] : $random(seed);
            b = (i < 6) ? corners[5 - i] : $random(seed);
            push_row(KIND_ALU, alu_op_e'(i[3:0]), DIV_DIV, src1_sel_e'(2'(i % 3)),
                     src2_sel_e'(1'((i / 3) % 2)), a, b, $random(seed), 0);
        end
        // branch compares, equal and random operands
        for (int i = 10; i < 16; i++) begin
            for (int m = 0; m < 4; m++) begin
                a = $random(seed);
                b = (m < 2) ? a : $random(seed);
                push_row(KIND_BRANCH, alu_op_e'(i[3:0]), DIV_DIV, SRC1_RS1, SRC2_RS2,
                         a, b, $random(seed), m % 2);
            end
        end
        a = $random(seed);
        push_row(KIND_BRANCH, ALU_EQ, DIV_DIV, SRC1_RS1, SRC2_RS2, a, a, 32'h40, 2);
        // jumps carry a non-add op to see the forced add
        for (int m = 0; m < 3; m++) begin
            push_row(KIND_JAL, ALU_SUB, DIV_DIV, SRC1_PC, SRC2_IMM,
                     $random(seed), $random(seed), $random(seed), m);
            push_row(KIND_JALR, ALU_XOR, DIV_DIV, SRC1_RS1, SRC2_IMM,
                     $random(seed), $random(seed), $random(seed), m);
        end
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 3; k++) begin
                b = $random(seed);
                b = (k == 0) ? b : (k == 1) ? b >> 20 : -(b >> 24);
                push_row(KIND_DIV, ALU_ADD, div_op_e'(i[1:0]), SRC1_RS1, SRC2_RS2,
                         $random(seed), b, '0, 0);
            end
            push_row(KIND_DIV, ALU_ADD, div_op_e'(i[1:0]), SRC1_RS1, SRC2_RS2,
                     $random(seed), '0, '0, 0);
            push_row(KIND_DIV, ALU_ADD, div_op_e'(i[1:0]), SRC1_RS1, SRC2_RS2,
                     min_neg, '1, '0, 0);
        end
        n_rows = rows.size();

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("out_valid after reset", `XLEN'(out_valid), '0);
        check_value("in_ready after reset", `XLEN'(in_ready), `XLEN'(1));

        for (int i = 0; i < n_rows; i++)
            run_row(i);

        if (n_results == n_rows) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("number of results taken differs from rows driven");
        end
    end

    // worst row is a divide plus its stall and handshake cycles
    initial begin : watchdog
        wait (n_rows > 0);
        repeat (n_rows * (`DIV_STEPS + 20) + 20) @(posedge clk);
        abort_run("watchdog expired before all rows completed");
    end

endmodule
